//--- Bender.yml
package:
  name: rdn

sources:
  - logic/rdn_pkg.sv
  - logic/rdn_weight_rom.sv
  - logic/rdn_layer.sv
  - logic/rdn_input_buffer.sv
  - logic/rdn_ctrl_unit.sv
  - logic/rdn_argmax.sv
  - logic/rdn_core.sv
  - target: test
    files:
      - tests/rdn_tb.sv

//--- logic/rdn_argmax.sv
`timescale 1ns/1ps

module rdn_argmax
  import rdn_pkg::*;
(
  input  rdn_scores_t scores,
  output logic [3:0]  class_idx
);

  // heap layout, 15 inner nodes and 16 leaves from node 15 up.
  rdn_sample_t node_val [2 * rdn_num_neurons + 1];
  logic [3:0]  node_idx [2 * rdn_num_neurons + 1];

  always_comb begin
    for (int i = 0; i <= rdn_num_neurons; i++) begin
      // the spare leaf scores zero and loses every tie.
      node_val[rdn_num_neurons + i] = (i < rdn_num_neurons) ? scores[i] : '0;
      node_idx[rdn_num_neurons + i] = i[3:0];
    end
    // left subtree always holds the lower indices.
    for (int k = rdn_num_neurons - 1; k >= 0; k--) begin
      if (node_val[2 * k + 1] >= node_val[2 * k + 2]) begin
        node_val[k] = node_val[2 * k + 1];
        node_idx[k] = node_idx[2 * k + 1];
      end else begin
        node_val[k] = node_val[2 * k + 2];
        node_idx[k] = node_idx[2 * k + 2];
      end
    end
  end

  assign class_idx = node_idx[0];  // root winner.

endmodule

//--- logic/rdn_core.sv
`timescale 1ns/1ps

module rdn_core
  import rdn_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        heu_out_ready,
  input  rdn_frame_t  frame,
  output logic        in_ready,
  input  logic        iru_in_ready,
  output logic        out_ready,
  output rdn_result_t result
);

  logic                 write_in;
  logic                 rotate_in;
  rdn_layer_ctl_t       a_ctl;
  rdn_layer_ctl_t       b_ctl;
  rdn_layer_ctl_t       c_ctl;
  logic [rdn_cnt_w-1:0] weight_idx;  // shared column index.
  rdn_sample_t          a_layer_in;  // buffer head.
  rdn_sample_t          b_layer_in;
  rdn_sample_t          c_layer_in;
  rdn_scores_t          a_scores;
  rdn_scores_t          b_scores;
  rdn_scores_t          c_scores;
  logic [3:0]           class_idx;

  rdn_ctrl_unit ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .heu_out_ready (heu_out_ready),
    .iru_in_ready  (iru_in_ready),
    .a_scores      (a_scores),
    .b_scores      (b_scores),
    .write_in      (write_in),
    .rotate_in     (rotate_in),
    .a_ctl         (a_ctl),
    .b_ctl         (b_ctl),
    .c_ctl         (c_ctl),
    .weight_idx    (weight_idx),
    .b_layer_in    (b_layer_in),
    .c_layer_in    (c_layer_in),
    .in_ready      (in_ready),
    .out_ready     (out_ready)
  );

  rdn_input_buffer buffer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .write_in  (write_in),
    .rotate_in (rotate_in),
    .frame     (frame),
    .head      (a_layer_in)
  );

  rdn_layer #(.layer(LAYER_A)) layer_a_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctl        (a_ctl),
    .layer_in   (a_layer_in),
    .weight_idx (weight_idx),
    .scores     (a_scores)
  );

  rdn_layer #(.layer(LAYER_B)) layer_b_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctl        (b_ctl),
    .layer_in   (b_layer_in),
    .weight_idx (weight_idx),
    .scores     (b_scores)
  );

  rdn_layer #(.layer(LAYER_C)) layer_c_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctl        (c_ctl),
    .layer_in   (c_layer_in),
    .weight_idx (weight_idx),
    .scores     (c_scores)
  );

  rdn_argmax argmax_inst (
    .scores    (c_scores),
    .class_idx (class_idx)
  );

  assign result = '{scores: c_scores, class_idx: class_idx};

endmodule

//--- logic/rdn_ctrl_unit.sv
`timescale 1ns/1ps

module rdn_ctrl_unit
  import rdn_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 heu_out_ready,
  input  logic                 iru_in_ready,
  input  rdn_scores_t          a_scores,
  input  rdn_scores_t          b_scores,
  output logic                 write_in,
  output logic                 rotate_in,
  output rdn_layer_ctl_t       a_ctl,
  output rdn_layer_ctl_t       b_ctl,
  output rdn_layer_ctl_t       c_ctl,
  output logic [rdn_cnt_w-1:0] weight_idx,
  output rdn_sample_t          b_layer_in,
  output rdn_sample_t          c_layer_in,
  output logic                 in_ready,
  output logic                 out_ready
);

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    A_CALC = 3'd1,
    B_CALC = 3'd2,
    C_CALC = 3'd3,
    DONE   = 3'd4
  } state_e;

  state_e               state;
  logic [rdn_cnt_w-1:0] cnt;  // shared by all three phases.

  logic a_run;
  logic b_run;
  logic c_run;
  logic a_last;
  logic b_last;
  logic c_last;

  assign a_run  = (state == A_CALC) && (cnt < rdn_num_inputs);
  assign b_run  = (state == B_CALC) && (cnt < rdn_num_neurons);
  assign c_run  = (state == C_CALC) && (cnt < rdn_num_neurons);
  assign a_last = (state == A_CALC) && (cnt == rdn_num_inputs);
  assign b_last = (state == B_CALC) && (cnt == rdn_num_neurons);
  assign c_last = (state == C_CALC) && (cnt == rdn_num_neurons);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (heu_out_ready) begin
            state <= A_CALC;
            cnt   <= '0;
          end
        end
        A_CALC: begin
          if (a_last) begin
            state <= B_CALC;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        B_CALC: begin
          if (b_last) begin
            state <= C_CALC;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        C_CALC: begin
          if (c_last) begin
            state <= iru_in_ready ? IDLE : DONE;  // result taken at once or held.
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        DONE: begin
          if (iru_in_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign in_ready  = (state == IDLE);
  assign write_in  = in_ready && heu_out_ready;  // accepting edge.
  assign rotate_in = a_run;                      // one sample per A cycle.

  // each layer clears on the last idle-ish cycle before it starts.
  assign a_ctl = '{clear: write_in, enable: a_run};
  assign b_ctl = '{clear: a_last, enable: b_run};
  assign c_ctl = '{clear: b_last, enable: c_run};

  assign weight_idx = cnt;

  // serialize the previous layer, zero outside the window.
  assign b_layer_in = b_run ? a_scores[cnt[3:0]] : '0;
  assign c_layer_in = c_run ? b_scores[cnt[3:0]] : '0;

  assign out_ready = c_last || (state == DONE);

endmodule

//--- logic/rdn_input_buffer.sv
`timescale 1ns/1ps

module rdn_input_buffer
  import rdn_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        write_in,
  input  logic        rotate_in,
  input  rdn_frame_t  frame,
  output rdn_sample_t head
);

  rdn_frame_t samples;  // sample 0 sits at the head.

  // load wins over rotate; the controller never asserts both.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      samples <= '0;
    end else if (write_in) begin
      samples <= frame;
    end else if (rotate_in) begin
      // head wraps to the top so 80 rotations restore the order.
      samples <= {samples[0], samples[rdn_num_inputs-1:1]};
    end
  end

  assign head = samples[0];  // current serial feature.

endmodule

//--- logic/rdn_layer.sv
`timescale 1ns/1ps

module rdn_layer
  import rdn_pkg::*;
#(
  parameter rdn_layer_e layer = LAYER_A
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rdn_layer_ctl_t       ctl,
  input  rdn_sample_t          layer_in,
  input  logic [rdn_cnt_w-1:0] weight_idx,
  output rdn_scores_t          scores
);

  logic signed [rdn_acc_w-1:0] acc [rdn_num_neurons];
  rdn_weight_col_t             column;  // weights for this input index.

  // shift right, then clamp into the unsigned score range.
  function automatic rdn_sample_t activate(input logic signed [rdn_acc_w-1:0] value);
    logic signed [rdn_acc_w-1:0] shifted;
    shifted = value >>> rdn_act_shift;
    if (shifted < 0) begin
      return '0;
    end else if (shifted > 2 ** rdn_data_w - 1) begin
      return '1;
    end else begin
      return shifted[rdn_data_w-1:0];
    end
  endfunction

  rdn_weight_rom rom_inst (
    .layer      (layer),
    .weight_idx (weight_idx),
    .column     (column)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int n = 0; n < rdn_num_neurons; n++) begin
        acc[n] <= '0;
      end
    end else if (ctl.clear) begin
      for (int n = 0; n < rdn_num_neurons; n++) begin
        acc[n] <= '0;
      end
    end else if (ctl.enable) begin
      // sample is unsigned, so pad a zero sign bit before the signed multiply.
      for (int n = 0; n < rdn_num_neurons; n++) begin
        acc[n] <= acc[n] + $signed({1'b0, layer_in}) * $signed(column[n]);
      end
    end
  end

  for (genvar n = 0; n < rdn_num_neurons; n++) begin : g_act
    assign scores[n] = activate(acc[n]);
  end

endmodule

//--- logic/rdn_pkg.sv
package rdn_pkg;

  // frame and layer geometry.
  localparam int rdn_num_inputs  = 80;  // features per frame.
  localparam int rdn_num_neurons = 15;  // neurons in every layer.

  // datapath widths.
  localparam int rdn_data_w   = 9;   // samples and scores, unsigned.
  localparam int rdn_weight_w = 4;   // two's complement weights.
  localparam int rdn_acc_w    = 20;  // holds 80 * 511 * 8 with sign.
  localparam int rdn_act_shift = 4;  // arithmetic shift before clamping.
  localparam int rdn_cnt_w    = 7;   // counts up to 80.

  // one feature sample or one neuron score.
  typedef logic [rdn_data_w-1:0] rdn_sample_t;

  // whole feature frame, sample 0 in the low bits.
  typedef rdn_sample_t [rdn_num_inputs-1:0] rdn_frame_t;

  // one score per neuron, neuron 0 in the low bits.
  typedef rdn_sample_t [rdn_num_neurons-1:0] rdn_scores_t;

  // one weight per neuron for a single input index.
  // each element is read back as a signed value.
  typedef logic [rdn_num_neurons-1:0][rdn_weight_w-1:0] rdn_weight_col_t;

  // per-layer strobes from the controller.
  typedef struct packed {
    logic clear;   // zero all accumulators.
    logic enable;  // accumulate this cycle's input.
  } rdn_layer_ctl_t;

  // layer selector, also picks the weight row base.
  typedef enum logic [1:0] {
    LAYER_A = 2'd0,
    LAYER_B = 2'd1,
    LAYER_C = 2'd2
  } rdn_layer_e;

  // what the core hands to the consumer.
  typedef struct packed {
    rdn_scores_t scores;     // layer C scores.
    logic [3:0]  class_idx;  // index of the largest score.
  } rdn_result_t;

endpackage

//--- logic/rdn_weight_rom.sv
`timescale 1ns/1ps

module rdn_weight_rom
  import rdn_pkg::*;
(
  input  rdn_layer_e           layer,
  input  logic [rdn_cnt_w-1:0] weight_idx,
  output rdn_weight_col_t      column
);

  // row-major, row = layer * 15 + neuron, 80 weights per row.
  logic [rdn_weight_w-1:0] mem [3 * rdn_num_neurons * rdn_num_inputs];

  initial begin
    $readmemh("logic/rdn_weights.hex", mem);
  end

  // B and C only use the first 15 entries of their rows.
  always_comb begin
    int row;
    for (int n = 0; n < rdn_num_neurons; n++) begin
      row = int'(layer) * rdn_num_neurons + n;
      column[n] = mem[row * rdn_num_inputs + int'(weight_idx)];
    end
  end

endmodule

//--- logic/rdn_weights.hex
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f f 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2
7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
e e e e e e e e e e e e e e e 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 4 4 4 4 4 4 4 4 4 4 4 4 4 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 3 3 3 3 3 3 3 3 3 3 3 3 3 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
7 7 7 7 7 7 7 7 7 7 7 7 7 7 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
f f f f f f f f f f f f f f f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 5 5 5 5 5 5 5 5 5 5 5 5 5 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
6 6 6 6 6 6 6 6 6 6 6 6 6 6 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
d d d d d d d d d d d d d d d 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

//--- sim.f
logic/rdn_pkg.sv
logic/rdn_weight_rom.sv
logic/rdn_layer.sv
logic/rdn_input_buffer.sv
logic/rdn_ctrl_unit.sv
logic/rdn_argmax.sv
logic/rdn_core.sv
tests/rdn_tb.sv

//--- tests/rdn_tb.sv
`timescale 1ns/1ps

module rdn_tb
  import rdn_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic        heu_out_ready;
  rdn_frame_t  frame;
  logic        in_ready;
  logic        iru_in_ready;
  logic        out_ready;
  rdn_result_t result;

  // trace records.
  string       rec_name [16];
  rdn_frame_t  rec_frame [16];
  int          rec_hold [16];
  rdn_scores_t rec_scores [16];
  logic [3:0]  rec_class [16];
  int          num_records;

  string  cur_name;
  int     test_errs;
  int     total_errs;
  int     tests_passed;
  int     tests_failed;
  integer seed = 94;
  int     cycles = 0;
  int     cycle_limit = 200 * 16 + 100;

  rdn_core rdn_core_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .heu_out_ready (heu_out_ready),
    .frame         (frame),
    .in_ready      (in_ready),
    .iru_in_ready  (iru_in_ready),
    .out_ready     (out_ready),
    .result        (result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run stopped, no progress after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic compare_scores(input string what, input rdn_scores_t exp,
                                input rdn_scores_t act);
    if (act !== exp) begin
      $display("ERR %s %s expected %h actual %h", cur_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic compare_class(input string what, input logic [3:0] exp,
                               input logic [3:0] act);
    if (act !== exp) begin
      $display("ERR %s %s expected %0d actual %0d", cur_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s %s expected %b actual %b", cur_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic compare_latency(input int exp, input int act);
    if (act != exp) begin
      $display("ERR %s latency expected %0d actual %0d", cur_name, exp, act);
      test_errs++;
    end
  endtask

  task automatic close_test();
    if (test_errs == 0) begin
      $display("test %s passed", cur_name);
      tests_passed++;
    end else begin
      $display("test %s failed with %0d errors", cur_name, test_errs);
      tests_failed++;
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;  // drive and sample away from the edge.
  endtask

  task automatic load_trace(output bit ok);
    int    fd;
    int    r;
    int    v;
    int    bad;
    string tok;
    string rest;
    ok = 1'b1;
    num_records = 0;
    fd = $fopen("tests/rdn_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/rdn_trace.txt");
      ok = 1'b0;
    end else begin
      while (ok && !$feof(fd)) begin
        r = $fscanf(fd, "%s", tok);
        if (r == 1) begin
          if (tok.substr(0, 0) == "#") begin
            r = $fgets(rest, fd);  // skip comment line.
          end else if (num_records == 16) begin
            $display("trace holds more than 16 records");
            ok = 1'b0;
          end else begin
            bad = 0;
            rec_name[num_records] = tok;
            for (int k = 0; k < rdn_num_inputs; k++) begin
              bad += ($fscanf(fd, "%d", v) != 1);
              rec_frame[num_records][k] = v[rdn_data_w-1:0];
            end
            bad += ($fscanf(fd, "%d", v) != 1);
            rec_hold[num_records] = v;
            for (int k = 0; k < rdn_num_neurons; k++) begin
              bad += ($fscanf(fd, "%d", v) != 1);
              rec_scores[num_records][k] = v[rdn_data_w-1:0];
            end
            bad += ($fscanf(fd, "%d", v) != 1);
            rec_class[num_records] = v[3:0];
            if (bad != 0) begin
              $display("trace record %s is incomplete", tok);
              ok = 1'b0;
            end
            num_records++;
          end
        end
      end
      $fclose(fd);
      if (ok && num_records == 0) begin
        $display("trace holds no records");
        ok = 1'b0;
      end
    end
  endtask

  task automatic run_record(input int i);
    int gap;
    int lat;
    cur_name = rec_name[i];
    // second half runs back to back, first half gets random idle gaps.
    gap = (i >= num_records / 2) ? 0 : $unsigned($random(seed)) % 4;
    if (gap > 0) begin
      heu_out_ready = 1'b0;
      repeat (gap) next_cycle();
    end
    frame         = rec_frame[i];
    heu_out_ready = 1'b1;
    iru_in_ready  = (rec_hold[i] == 0);
    while (!in_ready) next_cycle();
    next_cycle();  // accepting edge.
    frame = ~rec_frame[i];  // buffer keeps its own copy.
    lat = 0;
    while (!out_ready && lat <= 200) begin
      compare_bit("in_ready while busy", 1'b0, in_ready);
      next_cycle();
      lat++;
    end
    if (!out_ready) begin
      $display("%s: out_ready did not rise within 200 cycles", cur_name);
      test_errs++;
    end else begin
      compare_latency(112, lat);
      compare_scores("scores", rec_scores[i], result.scores);
      compare_class("class", rec_class[i], result.class_idx);
      repeat (rec_hold[i]) begin
        next_cycle();
        compare_bit("out_ready held", 1'b1, out_ready);
        compare_bit("in_ready held", 1'b0, in_ready);
        compare_scores("held scores", rec_scores[i], result.scores);
        compare_class("held class", rec_class[i], result.class_idx);
      end
      iru_in_ready = 1'b1;
      next_cycle();  // handshake edge.
      compare_bit("in_ready after handshake", 1'b1, in_ready);
      compare_bit("out_ready after handshake", 1'b0, out_ready);
    end
    close_test();
  endtask

  initial begin
    bit ok;
    rst_n         = 1'b0;
    heu_out_ready = 1'b0;
    iru_in_ready  = 1'b0;
    frame         = '0;
    test_errs     = 0;
    total_errs    = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    load_trace(ok);
    if (ok) begin
      cycle_limit = 200 * num_records + 100;
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    cur_name = "reset";
    compare_bit("in_ready", 1'b1, in_ready);
    compare_bit("out_ready", 1'b0, out_ready);
    close_test();
    if (ok) begin
      for (int i = 0; i < num_records; i++) begin
        run_record(i);
      end
    end
    $display("%0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, total_errs);
    if (ok && total_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tests/rdn_trace.txt
# columns: name, 80 samples (sample 0 first), cycles with iru_in_ready low,
# 15 expected scores (neuron 0 first), expected class; all numbers decimal
zero_frame 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
saturate 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 511 3 0 511 511 511 418 511 0 209 0 511 0 0 511 0 209 1
small_tie 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 0 0 59 44 104 29 104 0 14 0 74 0 0 89 0 14 3
ramp 0 1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 16 17 18 19 20 21 22 23 24 25 26 27 28 29 30 31 32 33 34 35 36 37 38 39 40 41 42 43 44 45 46 47 48 49 50 51 52 53 54 55 56 57 58 59 60 61 62 63 64 65 66 67 68 69 70 71 72 73 74 75 76 77 78 79 2 0 165 123 288 82 288 0 41 0 206 0 0 247 0 41 3
mid 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 5 0 511 450 511 300 511 0 150 0 511 0 0 511 0 150 1
negative_sum 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 200 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 0 0 511 387 511 258 511 0 129 0 511 0 0 511 0 129 1
quarter 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 50 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 1 0 312 234 511 156 511 0 78 0 390 0 0 468 0 78 3
